//--- src/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// Memory organization.
`define EE_BLOCKS       8
`define EE_BLOCK_DEPTH  256

// Upper nibble of the control byte.
`define EE_DEVICE_CODE  4'b1010

`define EE_SYNC_STAGES  2   // Flops per input line.

`endif

//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [7:0] ee_byte_t;
    typedef logic [7:0] ee_word_t;   // Address inside one block.
    typedef logic [2:0] ee_block_t;

    typedef enum logic [2:0] {
        st_idle,
        st_dev_addr,
        st_word_addr,
        st_write_data,
        st_read_data,
        st_ignore      // Not addressed, or read ended by NACK.
    } bus_state_e;

    // Control byte LSB.
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } bus_op_e;

endpackage

`default_nettype wire

//--- src/i2c_bus_frontend.sv
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_params.svh"

module i2c_bus_frontend (
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  scl,
    input  logic                  sdat_in,
    output logic                  ack_pull,
    output logic                  wr_en,
    output logic                  rd_en,
    output eeprom_pkg::ee_block_t blk_sel,
    output eeprom_pkg::ee_word_t  word_addr,
    output eeprom_pkg::ee_byte_t  wr_data,
    output logic                  load,
    output logic                  scl_fall,
    output logic                  scl_rise,
    output logic                  sdat_sync,
    input  logic                  byte_done,
    input  logic                  master_nack
);

    logic [`EE_SYNC_STAGES-1:0] scl_pipe;
    logic [`EE_SYNC_STAGES-1:0] sdat_pipe;
    logic                       scl_s;
    logic                       scl_d;
    logic                       sdat_d;
    logic                       start_cond;
    logic                       stop_cond;
    logic [3:0]                 bit_cnt;
    eeprom_pkg::ee_byte_t       rx_shift;
    eeprom_pkg::ee_byte_t       rx_byte;
    logic                       byte_rx;
    logic                       ack_pend;
    logic                       load_pend;
    eeprom_pkg::bus_state_e     state;

    // Bus idles high, so the synchronizers reset to ones.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_pipe  <= '1;
            sdat_pipe <= '1;
            scl_d     <= 1'b1;
            sdat_d    <= 1'b1;
        end
        else
        begin
            scl_pipe  <= {scl_pipe[`EE_SYNC_STAGES-2:0], scl};
            sdat_pipe <= {sdat_pipe[`EE_SYNC_STAGES-2:0], sdat_in};
            scl_d     <= scl_s;
            sdat_d    <= sdat_sync;
        end
    end

    assign scl_s     = scl_pipe[`EE_SYNC_STAGES-1];
    assign sdat_sync = sdat_pipe[`EE_SYNC_STAGES-1];
    assign scl_rise  = scl_s & ~scl_d;
    assign scl_fall  = ~scl_s & scl_d;

    // Data edges while the clock line stays high.
    assign start_cond = scl_s & scl_d & sdat_d & ~sdat_sync;
    assign stop_cond  = scl_s & scl_d & ~sdat_d & sdat_sync;

    assign rx_byte = {rx_shift[6:0], sdat_sync};
    assign byte_rx = scl_rise && (bit_cnt == 4'd7);

    // Counts data rises 0..7, then the ACK rise at 8.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
            bit_cnt <= 4'd0;
        else if (start_cond)
            bit_cnt <= 4'd0;
        else if (scl_rise)
        begin
            if (bit_cnt == 4'd8)
                bit_cnt <= 4'd0;
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge sda)
    begin
        if (scl_rise && !bit_cnt[3])
            rx_shift <= rx_byte;
    end

    // Held low across the whole ACK clock.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
            ack_pull <= 1'b0;
        else if (scl_fall)
            ack_pull <= (bit_cnt == 4'd8) && ack_pend;
    end

    assign load = load_pend & scl_fall;

    always_ff @(posedge sda)
    begin
        if ((state == eeprom_pkg::st_write_data) && byte_rx)
            wr_data <= rx_byte;
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state     <= eeprom_pkg::st_idle;
            blk_sel   <= '0;
            word_addr <= '0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            ack_pend  <= 1'b0;
            load_pend <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;

            if (wr_en || rd_en)
                word_addr <= word_addr + 8'd1;   // Wraps inside the block.

            if (rd_en)
                load_pend <= 1'b1;
            else if (scl_fall)
                load_pend <= 1'b0;

            if (scl_fall)
                ack_pend <= 1'b0;

            if (start_cond)
            begin
                state     <= eeprom_pkg::st_dev_addr;
                load_pend <= 1'b0;
            end
            else if (stop_cond)
            begin
                state     <= eeprom_pkg::st_idle;
                load_pend <= 1'b0;
            end
            else
            begin
                case (state)
                    eeprom_pkg::st_dev_addr:
                        if (byte_rx)
                        begin
                            if (rx_byte[7:4] == `EE_DEVICE_CODE)
                            begin
                                blk_sel  <= rx_byte[3:1];
                                ack_pend <= 1'b1;
                                if (eeprom_pkg::bus_op_e'(rx_byte[0]) == eeprom_pkg::op_read)
                                    state <= eeprom_pkg::st_read_data;
                                else
                                    state <= eeprom_pkg::st_word_addr;
                            end
                            else
                                state <= eeprom_pkg::st_ignore;  // No ACK.
                        end
                    eeprom_pkg::st_word_addr:
                        if (byte_rx)
                        begin
                            word_addr <= rx_byte;
                            ack_pend  <= 1'b1;
                            state     <= eeprom_pkg::st_write_data;
                        end
                    eeprom_pkg::st_write_data:
                        if (byte_rx)
                        begin
                            wr_en    <= 1'b1;
                            ack_pend <= 1'b1;
                        end
                    eeprom_pkg::st_read_data:
                        // First fetch on our own ACK of the read control byte.
                        if (scl_rise && ack_pull)
                            rd_en <= 1'b1;
                        else if (byte_done)
                        begin
                            if (master_nack)
                                state <= eeprom_pkg::st_ignore;
                            else
                                rd_en <= 1'b1;
                        end
                    default:
                        state <= state;   // Idle and ignore wait for start or stop.
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/eeprom_block.sv
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_params.svh"

module eeprom_block #(
    parameter int unsigned block_index = 0
) (
    input  logic                  sda,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  eeprom_pkg::ee_block_t blk_sel,
    input  eeprom_pkg::ee_word_t  word_addr,
    input  eeprom_pkg::ee_byte_t  wr_data,
    output eeprom_pkg::ee_byte_t  rd_data
);

    eeprom_pkg::ee_byte_t mem [`EE_BLOCK_DEPTH];
    logic                 blk_hit;

    // Block decode lives here only.
    assign blk_hit = (blk_sel == eeprom_pkg::ee_block_t'(block_index));

    always_ff @(posedge sda)
    begin
        if (wr_en && blk_hit)
            mem[word_addr] <= wr_data;
    end

    // Every block fetches, the shifter picks one.
    always_ff @(posedge sda)
    begin
        if (rd_en)
            rd_data <= mem[word_addr];
    end

endmodule

`default_nettype wire

//--- src/i2c_read_shifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_params.svh"

module i2c_read_shifter (
    input  logic                  sda,
    input  logic                  rst_n,
    input  eeprom_pkg::ee_byte_t  rd_data [`EE_BLOCKS],
    input  eeprom_pkg::ee_block_t blk_sel,
    input  logic                  load,
    input  logic                  scl_fall,
    input  logic                  scl_rise,
    input  logic                  sdat_sync,
    output logic                  data_pull,
    output logic                  byte_done,
    output logic                  master_nack
);

    eeprom_pkg::ee_byte_t tx_shift;
    logic [3:0]           tx_cnt;     // Clock rises seen in this byte.
    logic                 active;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
            tx_cnt <= 4'd0;
        end
        else if (load)
        begin
            active <= 1'b1;
            tx_cnt <= 4'd0;
        end
        else if (active && scl_rise)
        begin
            if (tx_cnt == 4'd8)
                active <= 1'b0;   // ACK bit sampled.
            else
                tx_cnt <= tx_cnt + 4'd1;
        end
    end

    // MSB first, next bit presented on each falling clock.
    always_ff @(posedge sda)
    begin
        if (load)
            tx_shift <= rd_data[blk_sel];
        else if (active && scl_fall)
            tx_shift <= {tx_shift[6:0], 1'b1};   // Ones shift in, freeing the ACK bit.
    end

    // Open drain, so only zeros are driven.
    assign data_pull = active && !tx_shift[7];

    assign byte_done   = active && scl_rise && (tx_cnt == 4'd8);
    assign master_nack = byte_done & sdat_sync;   // High line means NACK.

endmodule

`default_nettype wire

//--- src/i2c_eeprom.sv
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_params.svh"

module i2c_eeprom (
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic sdat_in,
    output logic sdat_oe
);

    logic                  ack_pull;
    logic                  data_pull;
    logic                  wr_en;
    logic                  rd_en;
    eeprom_pkg::ee_block_t blk_sel;
    eeprom_pkg::ee_word_t  word_addr;
    eeprom_pkg::ee_byte_t  wr_data;
    logic                  load;
    logic                  scl_fall;
    logic                  scl_rise;
    logic                  sdat_sync;
    logic                  byte_done;
    logic                  master_nack;
    eeprom_pkg::ee_byte_t  blk_rd_data [`EE_BLOCKS];

    i2c_bus_frontend i2c_bus_frontend_inst (
        .sda         (sda),
        .rst_n       (rst_n),
        .scl         (scl),
        .sdat_in     (sdat_in),
        .ack_pull    (ack_pull),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .blk_sel     (blk_sel),
        .word_addr   (word_addr),
        .wr_data     (wr_data),
        .load        (load),
        .scl_fall    (scl_fall),
        .scl_rise    (scl_rise),
        .sdat_sync   (sdat_sync),
        .byte_done   (byte_done),
        .master_nack (master_nack)
    );

    for (genvar i = 0; i < `EE_BLOCKS; i++)
    begin : g_block
        eeprom_block #(
            .block_index (i)
        ) eeprom_block_inst (
            .sda       (sda),
            .wr_en     (wr_en),
            .rd_en     (rd_en),
            .blk_sel   (blk_sel),
            .word_addr (word_addr),
            .wr_data   (wr_data),
            .rd_data   (blk_rd_data[i])
        );
    end

    i2c_read_shifter i2c_read_shifter_inst (
        .sda         (sda),
        .rst_n       (rst_n),
        .rd_data     (blk_rd_data),
        .blk_sel     (blk_sel),
        .load        (load),
        .scl_fall    (scl_fall),
        .scl_rise    (scl_rise),
        .sdat_sync   (sdat_sync),
        .data_pull   (data_pull),
        .byte_done   (byte_done),
        .master_nack (master_nack)
    );

    // Either side may pull the shared line low.
    assign sdat_oe = ack_pull | data_pull;

endmodule

`default_nettype wire

//--- verification/tb_i2c_eeprom.sv
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_params.svh"

module tb_i2c_eeprom;

    localparam int half_clks     = 8;    // Clocks per scl half period.
    localparam int mem_size      = `EE_BLOCKS * `EE_BLOCK_DEPTH;
    localparam int release_limit = 64;

    logic sda;
    logic rst_n;
    logic scl;
    logic sdat_in;
    logic sdat_oe;
    logic m_pull;   // Master's own pull on the data line.

    eeprom_pkg::ee_byte_t ref_mem   [mem_size];
    logic                 ref_valid [mem_size];
    eeprom_pkg::ee_byte_t wbuf      [8];
    logic [31:0]          rng;
    int                   err_cnt;
    int                   tests_ok;
    int                   tests_bad;

    i2c_eeprom i2c_eeprom_inst (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdat_in (sdat_in),
        .sdat_oe (sdat_oe)
    );

    // Wired data line, low if anyone pulls.
    assign sdat_in = ~(sdat_oe | m_pull);

    initial
    begin
        sda = 1'b0;
        forever #50 sda = ~sda;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic eeprom_pkg::ee_byte_t control_byte(input eeprom_pkg::ee_block_t blk,
                                                          input eeprom_pkg::bus_op_e op);
        return {`EE_DEVICE_CODE, blk, op};
    endfunction

    task automatic wait_clks(input int n);
        repeat (n) @(negedge sda);
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++)
        begin
            rng = xorshift(rng);
            wbuf[i] = rng[7:0];
        end
    endtask

    task automatic check_byte(input string name, input eeprom_pkg::ee_byte_t exp,
                              input eeprom_pkg::ee_byte_t act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic wait_release();
        int n;
        n = 0;
        while (sdat_oe && n < release_limit)
        begin
            @(negedge sda);
            n++;
        end
        if (sdat_oe)
        begin
            $display("timeout: the slave never released the data line");
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    // One scl clock. Data moves mid-low, sampled mid-high.
    task automatic clock_bit(input logic drive_low, output logic line);
        wait_clks(half_clks / 2);
        m_pull = drive_low;
        wait_clks(half_clks / 2);
        scl = 1'b1;
        wait_clks(half_clks / 2);
        line = sdat_in;
        wait_clks(half_clks / 2);
        scl = 1'b0;
    endtask

    task automatic send_start();
        wait_clks(half_clks / 2);
        wait_release();
        m_pull = 1'b0;
        wait_clks(half_clks / 2);
        scl = 1'b1;
        wait_clks(half_clks);
        m_pull = 1'b1;   // Data falls, clock high.
        wait_clks(half_clks);
        scl = 1'b0;
    endtask

    task automatic send_stop();
        wait_clks(half_clks / 2);
        wait_release();
        m_pull = 1'b1;
        wait_clks(half_clks / 2);
        scl = 1'b1;
        wait_clks(half_clks);
        m_pull = 1'b0;   // Data rises, clock high.
        wait_clks(half_clks);
    endtask

    task automatic send_byte(input eeprom_pkg::ee_byte_t data, output logic ack);
        logic line;
        for (int i = 7; i >= 0; i--)
            clock_bit(!data[i], line);
        clock_bit(1'b0, ack);   // Line left to the slave.
    endtask

    task automatic recv_byte(input logic nack, output eeprom_pkg::ee_byte_t data);
        logic line;
        data = '0;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b0, line);
            data[i] = line;
        end
        clock_bit(!nack, line);
    endtask

    task automatic write_bytes(input eeprom_pkg::ee_block_t blk,
                               input eeprom_pkg::ee_word_t addr, input int n);
        logic                 ack;
        eeprom_pkg::ee_word_t a;
        a = addr;
        send_start();
        send_byte(control_byte(blk, eeprom_pkg::op_write), ack);
        check_ack("ack", 1'b0, ack);
        send_byte(addr, ack);
        check_ack("ack", 1'b0, ack);
        for (int i = 0; i < n; i++)
        begin
            send_byte(wbuf[i], ack);
            check_ack("ack", 1'b0, ack);
            ref_mem[{blk, a}]   = wbuf[i];
            ref_valid[{blk, a}] = 1'b1;
            a = a + 8'd1;   // Stays in the block.
        end
        send_stop();
    endtask

    // Random read, dummy write then repeated start.
    task automatic read_bytes(input eeprom_pkg::ee_block_t blk,
                              input eeprom_pkg::ee_word_t addr, input int n);
        logic                 ack;
        eeprom_pkg::ee_byte_t data;
        eeprom_pkg::ee_word_t a;
        a = addr;
        send_start();
        send_byte(control_byte(blk, eeprom_pkg::op_write), ack);
        check_ack("ack", 1'b0, ack);
        send_byte(addr, ack);
        check_ack("ack", 1'b0, ack);
        send_start();
        send_byte(control_byte(blk, eeprom_pkg::op_read), ack);
        check_ack("ack", 1'b0, ack);
        for (int i = 0; i < n; i++)
        begin
            recv_byte(i == n - 1, data);
            if (ref_valid[{blk, a}])
                check_byte("rd_data", ref_mem[{blk, a}], data);
            else
            begin
                $display("read of block %0d address %h that was never written", blk, a);
                err_cnt++;
            end
            a = a + 8'd1;
        end
        send_stop();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before)
        begin
            $display("test %s ok", name);
            tests_ok++;
        end
        else
        begin
            $display("test %s failed", name);
            tests_bad++;
        end
    endtask

    task automatic test_reset();
        int e;
        e = err_cnt;
        repeat (20)
        begin
            wait_clks(1);
            check_ack("sdat_oe", 1'b0, sdat_oe);
        end
        report_test("reset", e);
    endtask

    task automatic test_single_byte();
        int e;
        e = err_cnt;
        fill_random(1);
        write_bytes(3'd2, 8'h10, 1);
        read_bytes(3'd2, 8'h10, 1);
        report_test("single_byte", e);
    endtask

    task automatic test_wrap();
        int e;
        e = err_cnt;
        fill_random(6);
        write_bytes(3'd5, 8'hfd, 6);
        read_bytes(3'd5, 8'hfd, 6);
        read_bytes(3'd5, 8'h00, 3);   // Wrapped bytes at the block base.
        report_test("sequential_wrap", e);
    endtask

    task automatic test_isolation();
        int e;
        e = err_cnt;
        for (int b = 0; b < `EE_BLOCKS; b++)
        begin
            wbuf[0] = eeprom_pkg::ee_byte_t'(8'h11 * (b + 1));
            write_bytes(eeprom_pkg::ee_block_t'(b), 8'h40, 1);
        end
        for (int b = 0; b < `EE_BLOCKS; b++)
            read_bytes(eeprom_pkg::ee_block_t'(b), 8'h40, 1);
        report_test("block_isolation", e);
    endtask

    task automatic test_bad_device();
        int   e;
        logic ack;
        e = err_cnt;
        send_start();
        send_byte(8'b1011_0000, ack);
        check_ack("ack", 1'b1, ack);
        send_byte(8'h40, ack);
        check_ack("ack", 1'b1, ack);
        send_byte(8'hee, ack);
        check_ack("ack", 1'b1, ack);
        send_stop();
        read_bytes(3'd0, 8'h40, 1);
        report_test("wrong_device_code", e);
    endtask

    task automatic test_stop_mid();
        int   e;
        logic ack;
        e = err_cnt;
        send_start();
        send_byte(control_byte(3'd3, eeprom_pkg::op_write), ack);
        check_ack("ack", 1'b0, ack);
        send_byte(8'h40, ack);
        check_ack("ack", 1'b0, ack);
        send_stop();
        scl = 1'b0;   // Clock low with data high, no start follows.
        send_byte(8'h5a, ack);   // Stray byte, an idle slave stays silent.
        check_ack("ack", 1'b1, ack);
        read_bytes(3'd3, 8'h40, 1);
        report_test("stop_mid_transaction", e);
    endtask

    initial
    begin
        rst_n     = 1'b0;
        scl       = 1'b1;
        m_pull    = 1'b0;
        rng       = 32'hd5e3;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (int i = 0; i < mem_size; i++)
            ref_valid[i] = 1'b0;
        wait_clks(5);
        rst_n = 1'b1;
        test_reset();
        test_single_byte();
        test_wrap();
        test_isolation();
        test_bad_device();
        test_stop_mid();
        $display("tests passed %0d failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/eeprom_pkg.sv
src/i2c_bus_frontend.sv
src/eeprom_block.sv
src/i2c_read_shifter.sv
src/i2c_eeprom.sv
verification/tb_i2c_eeprom.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_eeprom
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
